// File: verilog/lsu_pkg.sv
// memory subsystem shared definitions
package lsu_pkg;

  // bus widths
  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int strb_w = 4;

  // axi response codes
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // load operation encoding
  // bit 1 set means word, bits 1:0 clear means byte
  // bit 2 set means zero extension
  typedef enum logic [2:0] {
    op_lb  = 3'd0,
    op_lh  = 3'd1,
    op_lw  = 3'd2,
    op_lbu = 3'd4,
    op_lhu = 3'd5
  } load_op_e;

endpackage

// File: verilog/axi_lite_if.sv
// axi-lite bus
interface axi_lite_if import lsu_pkg::*; ();

  // write address, write data, write response
  logic              awvalid, awready;
  logic [addr_w-1:0] awaddr;
  logic              wvalid, wready;
  logic [data_w-1:0] wdata;
  logic [strb_w-1:0] wstrb;
  logic              bvalid, bready;
  logic [1:0]        bresp;

  // read address, read data
  logic              arvalid, arready;
  logic [addr_w-1:0] araddr;
  logic              rvalid, rready;
  logic [data_w-1:0] rdata;
  logic [1:0]        rresp;

  modport master (
    output awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
    input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
  );

  modport slave (
    input  awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
    output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
  );

endinterface

// File: verilog/lsu_align.sv
// load/store byte alignment
module lsu_align import lsu_pkg::*; (
  input  logic [1:0]        addr_low,
  input  logic [data_w-1:0] wdata,
  input  logic [strb_w-1:0] wmask,
  input  load_op_e          load_op,
  input  logic [data_w-1:0] word0,
  input  logic [data_w-1:0] word1,
  output logic [data_w-1:0] wdata_lane,
  output logic [strb_w-1:0] strb0,
  output logic [strb_w-1:0] strb1,
  output logic              split_store,
  output logic              split_load,
  output logic [data_w-1:0] load_value
);

  logic [2*data_w-1:0] wdata_rot;
  logic [2*strb_w-1:0] strb_wide;
  logic [2*data_w-1:0] rd_pair;
  logic [data_w-1:0]   merged;
  logic [2:0]          size_bytes;
  logic [2:0]          end_byte;
  logic [4:0]          bit_shift;

  assign bit_shift = {addr_low, 3'b000};

  // store side
  // rotating a doubled copy puts the spilled bytes back into the low lanes
  assign wdata_rot   = {wdata, wdata} << bit_shift;
  assign wdata_lane  = wdata_rot[2*data_w-1:data_w];
  assign strb_wide   = {{strb_w{1'b0}}, wmask} << addr_low;
  assign strb0       = strb_wide[strb_w-1:0];
  assign strb1       = strb_wide[2*strb_w-1:strb_w];
  assign split_store = |strb1;

  // load side
  always_comb begin
    if (load_op[1]) begin
      size_bytes = 3'd4;
    end else if (load_op[0]) begin
      size_bytes = 3'd2;
    end else begin
      size_bytes = 3'd1;
    end
  end

  assign end_byte   = {1'b0, addr_low} + size_bytes;
  assign split_load = end_byte > 3'd4;

  // bytes from word0 at the offset, then on into word1
  assign rd_pair = {word1, word0} >> bit_shift;
  assign merged  = rd_pair[data_w-1:0];

  always_comb begin
    case (load_op)
      op_lb:   load_value = {{24{merged[7]}}, merged[7:0]};
      op_lh:   load_value = {{16{merged[15]}}, merged[15:0]};
      op_lbu:  load_value = {24'b0, merged[7:0]};
      op_lhu:  load_value = {16'b0, merged[15:0]};
      default: load_value = merged;
    endcase
  end

endmodule

// File: verilog/lsu.sv
// load/store unit
module lsu import lsu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              valid,
  input  logic              ren,
  input  logic              wen,
  input  logic [addr_w-1:0] addr,
  input  logic [data_w-1:0] wdata,
  input  logic [strb_w-1:0] wmask,
  input  load_op_e          load_op,
  output logic              ready,
  output logic              done,
  output logic [data_w-1:0] rdata,
  output logic              err,
  axi_lite_if.master        bus
);

  typedef enum logic [1:0] {st_idle, st_first, st_mid, st_last} state_e;

  state_e            state;
  logic              is_write;
  logic              arvalid_q, awvalid_q, wvalid_q;
  logic              done_q, err_q;
  logic [addr_w-1:0] word_addr;
  logic [1:0]        addr_low;
  logic [data_w-1:0] wdata_q, word0, word1, wdata_lane;
  logic [strb_w-1:0] wmask_q, strb0, strb1;
  load_op_e          load_op_q;
  logic              split_store, split_load, split;
  logic              accept, resp_fire, resp_bad;

  lsu_align align_i (
    .addr_low    (addr_low),
    .wdata       (wdata_q),
    .wmask       (wmask_q),
    .load_op     (load_op_q),
    .word0       (word0),
    .word1       (word1),
    .wdata_lane  (wdata_lane),
    .strb0       (strb0),
    .strb1       (strb1),
    .split_store (split_store),
    .split_load  (split_load),
    .load_value  (rdata)
  );

  assign ready     = (state == st_idle);
  assign accept    = valid && ready;
  assign split     = is_write ? split_store : split_load;
  assign resp_fire = is_write ? (bus.bvalid && bus.bready) : (bus.rvalid && bus.rready);
  assign resp_bad  = (is_write ? bus.bresp : bus.rresp) != resp_okay;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_idle;
      is_write  <= 1'b0;
      arvalid_q <= 1'b0;
      awvalid_q <= 1'b0;
      wvalid_q  <= 1'b0;
      done_q    <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (bus.arvalid && bus.arready) arvalid_q <= 1'b0;
      if (bus.awvalid && bus.awready) awvalid_q <= 1'b0;
      if (bus.wvalid && bus.wready) wvalid_q <= 1'b0;
      case (state)
        st_idle: begin
          if (accept) begin
            // a store wins when both enables are set
            is_write <= wen;
            err_q    <= 1'b0;
            if (wen || ren) begin
              awvalid_q <= wen;
              wvalid_q  <= wen;
              arvalid_q <= ren && !wen;
              state     <= st_first;
            end else begin
              done_q <= 1'b1;
            end
          end
        end
        st_first: begin
          if (resp_fire) begin
            err_q <= err_q || resp_bad;
            if (split) begin
              state <= st_mid;
            end else begin
              done_q <= 1'b1;
              state  <= st_idle;
            end
          end
        end
        st_mid: begin
          // second word, address already advanced below
          awvalid_q <= is_write;
          wvalid_q  <= is_write;
          arvalid_q <= !is_write;
          state     <= st_last;
        end
        default: begin
          if (resp_fire) begin
            err_q  <= err_q || resp_bad;
            done_q <= 1'b1;
            state  <= st_idle;
          end
        end
      endcase
    end
  end

  // request and read data capture
  always_ff @(posedge clk) begin
    if (accept) begin
      word_addr <= {addr[addr_w-1:2], 2'b00};
      addr_low  <= addr[1:0];
      wdata_q   <= wdata;
      wmask_q   <= wmask;
      load_op_q <= load_op;
    end
    if (state == st_mid) word_addr <= word_addr + addr_w'(4);
    if (state == st_first && resp_fire) word0 <= bus.rdata;
    if (state == st_last && resp_fire) word1 <= bus.rdata;
  end

  assign bus.awvalid = awvalid_q;
  assign bus.awaddr  = word_addr;
  assign bus.wvalid  = wvalid_q;
  assign bus.wdata   = wdata_lane;
  assign bus.wstrb   = (state == st_last) ? strb1 : strb0;
  assign bus.bready  = 1'b1;
  assign bus.arvalid = arvalid_q;
  assign bus.araddr  = word_addr;
  assign bus.rready  = 1'b1;

  assign done = done_q;
  assign err  = err_q;

endmodule

// File: verilog/fetch_unit.sv
// instruction fetch master
module fetch_unit import lsu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              valid,
  input  logic [addr_w-1:0] pc,
  output logic              ready,
  output logic              done,
  output logic [data_w-1:0] instr,
  output logic              err,
  axi_lite_if.master        bus
);

  typedef enum logic {st_idle, st_wait} state_e;

  state_e            state;
  logic              arvalid_q, done_q, err_q;
  logic [addr_w-1:0] araddr_q;
  logic [data_w-1:0] instr_q;

  assign ready = (state == st_idle);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_idle;
      arvalid_q <= 1'b0;
      done_q    <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (state == st_idle) begin
        if (valid) begin
          arvalid_q <= 1'b1;
          state     <= st_wait;
        end
      end else begin
        if (bus.arvalid && bus.arready) arvalid_q <= 1'b0;
        if (bus.rvalid && bus.rready) begin
          err_q  <= bus.rresp != resp_okay;
          done_q <= 1'b1;
          state  <= st_idle;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (valid && ready) araddr_q <= {pc[addr_w-1:2], 2'b00};
    if (bus.rvalid && bus.rready) instr_q <= bus.rdata;
  end

  // read-only master, write channels stay quiet
  assign bus.awvalid = 1'b0;
  assign bus.awaddr  = '0;
  assign bus.wvalid  = 1'b0;
  assign bus.wdata   = '0;
  assign bus.wstrb   = '0;
  assign bus.bready  = 1'b1;
  assign bus.arvalid = arvalid_q;
  assign bus.araddr  = araddr_q;
  assign bus.rready  = 1'b1;

  assign done  = done_q;
  assign instr = instr_q;
  assign err   = err_q;

endmodule

// File: verilog/axi_arbiter.sv
// two-master axi-lite round-robin arbiter
module axi_arbiter import lsu_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  axi_lite_if.slave  m0,
  axi_lite_if.slave  m1,
  axi_lite_if.master s
);

  logic grant_q, busy_q, last_q;
  logic req0, req1, pick, sel, resp_done;

  assign req0 = m0.arvalid || m0.awvalid;
  assign req1 = m1.arvalid || m1.awvalid;

  // on a tie the master not served last wins
  assign pick      = (req0 && req1) ? !last_q : req1;
  assign sel       = busy_q ? grant_q : pick;
  assign resp_done = (s.rvalid && s.rready) || (s.bvalid && s.bready);

  always_ff @(posedge clk) begin
    if (rst) begin
      grant_q <= 1'b0;
      busy_q  <= 1'b0;
      last_q  <= 1'b1;
    end else if (!busy_q) begin
      if (req0 || req1) begin
        grant_q <= pick;
        last_q  <= pick;
        busy_q  <= 1'b1;
      end
    end else if (resp_done) begin
      busy_q <= 1'b0;
    end
  end

  // request channels from the selected master
  assign s.awvalid = sel ? m1.awvalid : m0.awvalid;
  assign s.awaddr  = sel ? m1.awaddr : m0.awaddr;
  assign s.wvalid  = sel ? m1.wvalid : m0.wvalid;
  assign s.wdata   = sel ? m1.wdata : m0.wdata;
  assign s.wstrb   = sel ? m1.wstrb : m0.wstrb;
  assign s.bready  = sel ? m1.bready : m0.bready;
  assign s.arvalid = sel ? m1.arvalid : m0.arvalid;
  assign s.araddr  = sel ? m1.araddr : m0.araddr;
  assign s.rready  = sel ? m1.rready : m0.rready;

  // ready and response back to the selected master only
  assign m0.awready = !sel && s.awready;
  assign m0.wready  = !sel && s.wready;
  assign m0.bvalid  = !sel && s.bvalid;
  assign m0.bresp   = s.bresp;
  assign m0.arready = !sel && s.arready;
  assign m0.rvalid  = !sel && s.rvalid;
  assign m0.rdata   = s.rdata;
  assign m0.rresp   = s.rresp;

  assign m1.awready = sel && s.awready;
  assign m1.wready  = sel && s.wready;
  assign m1.bvalid  = sel && s.bvalid;
  assign m1.bresp   = s.bresp;
  assign m1.arready = sel && s.arready;
  assign m1.rvalid  = sel && s.rvalid;
  assign m1.rdata   = s.rdata;
  assign m1.rresp   = s.rresp;

endmodule

// File: verilog/axi_sram.sv
// axi-lite word memory
module axi_sram import lsu_pkg::*; #(
  parameter int mem_words = 256
) (
  input  logic      clk,
  input  logic      rst,
  axi_lite_if.slave bus
);

  localparam int idx_w = $clog2(mem_words);
  localparam logic [addr_w-3:0] depth = (addr_w - 2)'(mem_words);

  logic [data_w-1:0] mem [mem_words];
  logic              pending, ar_fire, wr_fire, rd_ok, wr_ok;
  logic [idx_w-1:0]  rd_idx, wr_idx;
  logic              rvalid_q, bvalid_q;
  logic [1:0]        rresp_q, bresp_q;
  logic [data_w-1:0] rdata_q;

  assign pending = rvalid_q || bvalid_q;

  // reads go first, a write needs both channels at once
  assign bus.arready = !pending;
  assign bus.awready = !pending && !bus.arvalid && bus.wvalid;
  assign bus.wready  = !pending && !bus.arvalid && bus.awvalid;

  assign ar_fire = bus.arvalid && bus.arready;
  assign wr_fire = bus.awvalid && bus.awready;

  assign rd_idx = bus.araddr[idx_w+1:2];
  assign wr_idx = bus.awaddr[idx_w+1:2];
  assign rd_ok  = bus.araddr[addr_w-1:2] < depth;
  assign wr_ok  = bus.awaddr[addr_w-1:2] < depth;

  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid_q <= 1'b0;
      bvalid_q <= 1'b0;
      rresp_q  <= resp_okay;
      bresp_q  <= resp_okay;
      rdata_q  <= '0;
    end else begin
      if (bus.rvalid && bus.rready) rvalid_q <= 1'b0;
      if (bus.bvalid && bus.bready) bvalid_q <= 1'b0;
      if (ar_fire) begin
        rvalid_q <= 1'b1;
        rresp_q  <= rd_ok ? resp_okay : resp_slverr;
        rdata_q  <= rd_ok ? mem[rd_idx] : '0;
      end
      if (wr_fire) begin
        bvalid_q <= 1'b1;
        bresp_q  <= wr_ok ? resp_okay : resp_slverr;
      end
    end
  end

  // strobed byte write, out of range is dropped
  always_ff @(posedge clk) begin
    if (wr_fire && wr_ok) begin
      for (int i = 0; i < strb_w; i++) begin
        if (bus.wstrb[i]) mem[wr_idx][i*8 +: 8] <= bus.wdata[i*8 +: 8];
      end
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.rresp  = rresp_q;
  assign bus.bvalid = bvalid_q;
  assign bus.bresp  = bresp_q;

endmodule

// File: verilog/mem_subsys_top.sv
// memory subsystem top level
module mem_subsys_top import lsu_pkg::*; #(
  parameter int mem_words = 256
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              lsu_valid,
  input  logic              lsu_ren,
  input  logic              lsu_wen,
  input  logic [addr_w-1:0] lsu_addr,
  input  logic [data_w-1:0] lsu_wdata,
  input  logic [strb_w-1:0] lsu_wmask,
  input  load_op_e          lsu_load_op,
  output logic              lsu_ready,
  output logic              lsu_done,
  output logic [data_w-1:0] lsu_rdata,
  output logic              lsu_err,
  input  logic              ifu_valid,
  input  logic [addr_w-1:0] ifu_pc,
  output logic              ifu_ready,
  output logic              ifu_done,
  output logic [data_w-1:0] ifu_instr,
  output logic              ifu_err
);

  axi_lite_if lsu_bus ();
  axi_lite_if ifu_bus ();
  axi_lite_if mem_bus ();

  lsu lsu_i (
    .clk     (clk),
    .rst     (rst),
    .valid   (lsu_valid),
    .ren     (lsu_ren),
    .wen     (lsu_wen),
    .addr    (lsu_addr),
    .wdata   (lsu_wdata),
    .wmask   (lsu_wmask),
    .load_op (lsu_load_op),
    .ready   (lsu_ready),
    .done    (lsu_done),
    .rdata   (lsu_rdata),
    .err     (lsu_err),
    .bus     (lsu_bus)
  );

  fetch_unit fetch_i (
    .clk   (clk),
    .rst   (rst),
    .valid (ifu_valid),
    .pc    (ifu_pc),
    .ready (ifu_ready),
    .done  (ifu_done),
    .instr (ifu_instr),
    .err   (ifu_err),
    .bus   (ifu_bus)
  );

  // lsu on port 0, fetch on port 1
  axi_arbiter arb_i (
    .clk (clk),
    .rst (rst),
    .m0  (lsu_bus),
    .m1  (ifu_bus),
    .s   (mem_bus)
  );

  axi_sram #(
    .mem_words (mem_words)
  ) sram_i (
    .clk (clk),
    .rst (rst),
    .bus (mem_bus)
  );

endmodule

// File: tb/tb_top.sv
// memory subsystem testbench
module tb_top import lsu_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int mem_words = 256;
  localparam int mem_bytes = mem_words * 4;
  localparam int byte_bits = $clog2(mem_bytes);
  localparam int reset_cycles = 8;

  logic clk, rst;
  logic lsu_valid, lsu_ren, lsu_wen;
  logic [31:0] lsu_addr, lsu_wdata;
  logic [3:0] lsu_wmask;
  load_op_e lsu_load_op;
  logic lsu_ready, lsu_done, lsu_err;
  logic [31:0] lsu_rdata;
  logic ifu_valid;
  logic [31:0] ifu_pc;
  logic ifu_ready, ifu_done, ifu_err;
  logic [31:0] ifu_instr;

  // byte model of the memory and the expectations in issue order
  logic [7:0] ref_mem [mem_bytes];
  logic [31:0] lsu_exp_data [$];
  bit lsu_exp_err [$];
  bit lsu_exp_load [$];
  logic [31:0] ifu_exp_data [$];
  bit ifu_exp_err [$];
  logic [31:0] lsu_want, ifu_want;
  bit lsu_want_err, lsu_want_load, ifu_want_err;
  int lsu_sent, ifu_sent;
  int cycles;
  int seed;

  mem_subsys_top #(.mem_words(mem_words)) dut_i (
    .clk(clk), .rst(rst),
    .lsu_valid(lsu_valid), .lsu_ren(lsu_ren), .lsu_wen(lsu_wen),
    .lsu_addr(lsu_addr), .lsu_wdata(lsu_wdata), .lsu_wmask(lsu_wmask),
    .lsu_load_op(lsu_load_op), .lsu_ready(lsu_ready), .lsu_done(lsu_done),
    .lsu_rdata(lsu_rdata), .lsu_err(lsu_err),
    .ifu_valid(ifu_valid), .ifu_pc(ifu_pc), .ifu_ready(ifu_ready),
    .ifu_done(ifu_done), .ifu_instr(ifu_instr), .ifu_err(ifu_err)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  // size rule: bit 1 set is a word, bits 1:0 clear a byte, else a half-word
  function automatic int op_size(input load_op_e op);
    if (op[1]) return 4;
    if (op[1:0] == 2'b00) return 1;
    return 2;
  endfunction

  function automatic load_op_e op_pick(input logic [2:0] k);
    case (k)
      3'd0: return op_lb;
      3'd1: return op_lh;
      3'd2: return op_lw;
      3'd3: return op_lbu;
      default: return op_lhu;
    endcase
  endfunction

  function automatic bit byte_in_range(input logic [31:0] a);
    return (a >> 2) < 32'(mem_words);
  endfunction

  function automatic bit range_err(input logic [31:0] addr, input int size);
    bit bad;
    bad = 1'b0;
    for (int k = 0; k < size; k++) begin
      if (!byte_in_range(addr + 32'(k))) bad = 1'b1;
    end
    return bad;
  endfunction

  // bytes from addr upward, zero outside the range, then extension
  function automatic logic [31:0] load_ref(input logic [31:0] addr, input load_op_e op);
    logic [31:0] val;
    logic [31:0] a;
    int size;
    size = op_size(op);
    val = '0;
    for (int k = 0; k < size; k++) begin
      a = addr + 32'(k);
      if (byte_in_range(a)) val[8*k +: 8] = ref_mem[a[byte_bits-1:0]];
    end
    if (!op[2] && size == 1) val = {{24{val[7]}}, val[7:0]};
    if (!op[2] && size == 2) val = {{16{val[15]}}, val[15:0]};
    return val;
  endfunction

  // byte k of the store data lands at addr + k
  task automatic store_model(input logic [31:0] addr, input logic [31:0] data, input int size);
    logic [31:0] a;
    for (int k = 0; k < size; k++) begin
      a = addr + 32'(k);
      if (byte_in_range(a)) ref_mem[a[byte_bits-1:0]] = data[8*k +: 8];
    end
  endtask

  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]};
  endfunction

  // called and returning on a falling edge
  task automatic lsu_issue(input bit is_store, input logic [31:0] addr,
                           input logic [31:0] data, input int size, input load_op_e op);
    int s;
    s = is_store ? size : op_size(op);
    lsu_exp_err.push_back(range_err(addr, s));
    lsu_exp_load.push_back(!is_store);
    if (is_store) begin
      store_model(addr, data, size);
      lsu_exp_data.push_back('0);
    end else begin
      lsu_exp_data.push_back(load_ref(addr, op));
    end
    lsu_sent++;
    lsu_valid = 1'b1;
    lsu_ren = !is_store;
    lsu_wen = is_store;
    lsu_addr = addr;
    lsu_wdata = data;
    lsu_wmask = (size == 4) ? 4'hf : (size == 2) ? 4'h3 : 4'h1;
    lsu_load_op = op;
    while (!lsu_ready) @(negedge clk);
    @(negedge clk);
    lsu_valid = 1'b0;
  endtask

  task automatic fetch_issue(input logic [31:0] pc);
    ifu_exp_err.push_back(!byte_in_range(pc));
    ifu_exp_data.push_back(load_ref({pc[31:2], 2'b00}, op_lw));
    ifu_sent++;
    ifu_valid = 1'b1;
    ifu_pc = pc;
    while (!ifu_ready) @(negedge clk);
    @(negedge clk);
    ifu_valid = 1'b0;
  endtask

  task automatic wait_idle();
    while (lsu_exp_data.size() != 0 || ifu_exp_data.size() != 0) @(negedge clk);
  endtask

  task automatic random_lsu_run(input int count);
    logic [31:0] r;
    logic [31:0] addr;
    bit is_store;
    int size;
    for (int n = 0; n < count; n++) begin
      r = $random(seed);
      addr = $random(seed);
      is_store = r[0];
      size = (r[2:1] == 2'd0) ? 1 : (r[2:1] == 2'd1) ? 2 : 4;
      // stores stay below the fetch region
      addr = is_store ? addr % 32'h2fc : addr % 32'h3fc;
      lsu_issue(is_store, addr, $random(seed), size, op_pick(3'(r[10:3] % 8'd5)));
      repeat (r[12:11]) @(negedge clk);
    end
  endtask

  task automatic random_fetch_run(input int count);
    logic [31:0] r;
    for (int n = 0; n < count; n++) begin
      r = $random(seed);
      fetch_issue(32'h300 + r % 32'h100);
      repeat (r[9:8]) @(negedge clk);
    end
  endtask

  // compare on done, sampled mid-cycle
  always @(negedge clk) begin
    if (!rst && lsu_done) begin
      assert (lsu_exp_data.size() > 0)
        else stop_with_error("lsu done pulsed with no request outstanding");
      lsu_want = lsu_exp_data.pop_front();
      lsu_want_err = lsu_exp_err.pop_front();
      lsu_want_load = lsu_exp_load.pop_front();
      assert (lsu_err == lsu_want_err)
        else stop_with_error($sformatf("MISMATCH lsu_err got %0h expected %0h",
                                       lsu_err, lsu_want_err));
      if (lsu_want_load) begin
        assert (lsu_rdata == lsu_want)
          else stop_with_error($sformatf("MISMATCH lsu_rdata got %08h expected %08h",
                                         lsu_rdata, lsu_want));
      end
    end
    if (!rst && ifu_done) begin
      assert (ifu_exp_data.size() > 0)
        else stop_with_error("fetch done pulsed with no request outstanding");
      ifu_want = ifu_exp_data.pop_front();
      ifu_want_err = ifu_exp_err.pop_front();
      assert (ifu_err == ifu_want_err)
        else stop_with_error($sformatf("MISMATCH ifu_err got %0h expected %0h",
                                       ifu_err, ifu_want_err));
      assert (ifu_instr == ifu_want)
        else stop_with_error($sformatf("MISMATCH ifu_instr got %08h expected %08h",
                                       ifu_instr, ifu_want));
    end
  end

  // budget of 40 cycles for every request issued so far
  always @(posedge clk) begin
    cycles++;
    if (cycles > 40 * (lsu_sent + ifu_sent + 1) + reset_cycles) begin
      stop_with_error("timeout, a request never completed");
    end
  end

  initial begin
    seed = 47;
    rst = 1'b1;
    lsu_valid = 1'b0;
    lsu_ren = 1'b0;
    lsu_wen = 1'b0;
    lsu_addr = '0;
    lsu_wdata = '0;
    lsu_wmask = '0;
    lsu_load_op = op_lw;
    ifu_valid = 1'b0;
    ifu_pc = '0;
    repeat (reset_cycles) @(negedge clk);

    // both sides idle and quiet out of reset
    assert ({lsu_ready, ifu_ready} == 2'b11)
      else stop_with_error($sformatf("MISMATCH {lsu_ready, ifu_ready} got %0h expected %0h",
                                     {lsu_ready, ifu_ready}, 2'b11));
    assert ({lsu_done, ifu_done} == 2'b00)
      else stop_with_error($sformatf("MISMATCH {lsu_done, ifu_done} got %0h expected %0h",
                                     {lsu_done, ifu_done}, 2'b00));
    rst = 1'b0;

    // fill every word through the lsu
    for (int w = 0; w < mem_words; w++) begin
      lsu_issue(1'b1, 32'(w * 4), fill_word(32'(w * 4)), 4, op_lw);
    end

    // aligned stores, then every load op at every aligned offset
    lsu_issue(1'b1, 32'h40, 32'h80f0_7f81, 4, op_lw);
    lsu_issue(1'b1, 32'h46, 32'h0000_9a7e, 2, op_lw);
    lsu_issue(1'b1, 32'h49, 32'h0000_00c3, 1, op_lw);
    for (int o = 0; o < 5; o++) begin
      for (int off = 0; off < 12; off++) begin
        if (off % op_size(op_pick(3'(o))) == 0) begin
          lsu_issue(1'b0, 32'h40 + 32'(off), '0, 4, op_pick(3'(o)));
        end
      end
    end

    // stores and loads across word boundaries
    lsu_issue(1'b1, 32'h81, 32'hdead_beef, 4, op_lw);
    lsu_issue(1'b1, 32'h8b, 32'h0000_f00d, 2, op_lw);
    lsu_issue(1'b1, 32'h8e, 32'h8765_4321, 4, op_lw);
    for (int o = 0; o < 5; o++) begin
      for (int a = 32'h80; a < 32'h94; a++) begin
        lsu_issue(1'b0, 32'(a), '0, 4, op_pick(3'(o)));
      end
    end

    // fetches of words the lsu wrote
    wait_idle();
    for (int a = 32'h40; a < 32'h4c; a += 4) fetch_issue(32'(a));
    for (int a = 32'h80; a < 32'h94; a += 4) fetch_issue(32'(a));
    fetch_issue(32'h83);

    // both sides raised in the same cycle, separate regions
    wait_idle();
    for (int i = 0; i < 24; i++) begin
      fork
        lsu_issue(i[0], 32'h100 + 32'(i * 5), 32'hc0de_0000 ^ 32'(i * 7), 4 >> (i % 3),
                  op_pick(3'(i % 5)));
        fetch_issue(32'h200 + 32'(i * 4));
      join
    end

    // out of range accesses
    wait_idle();
    lsu_issue(1'b1, 32'h400, 32'h1234_5678, 4, op_lw);
    lsu_issue(1'b1, 32'h1000_0000, 32'h55aa_55aa, 4, op_lw);
    lsu_issue(1'b0, 32'h400, '0, 4, op_lw);
    lsu_issue(1'b0, 32'h400, '0, 4, op_lbu);
    lsu_issue(1'b1, 32'h3fe, 32'ha5b6_c7d8, 4, op_lw);
    lsu_issue(1'b0, 32'h3fc, '0, 4, op_lw);
    lsu_issue(1'b0, 32'h3fe, '0, 4, op_lh);
    lsu_issue(1'b0, 32'h3ff, '0, 4, op_lh);
    lsu_issue(1'b0, 32'h000, '0, 4, op_lw);
    wait_idle();
    fetch_issue(32'h404);
    fetch_issue(32'h3fc);

    // random mixed traffic
    wait_idle();
    fork
      random_lsu_run(200);
      random_fetch_run(80);
    join

    // both units back in idle once every request has completed
    wait_idle();
    if (lsu_ready && ifu_ready) begin
      $display("test passed");
      $finish;
    end else begin
      stop_with_error("a unit did not return to idle after its last request");
    end
  end

endmodule

// File: sim.f
verilog/lsu_pkg.sv
verilog/axi_lite_if.sv
verilog/lsu_align.sv
verilog/lsu.sv
verilog/fetch_unit.sv
verilog/axi_arbiter.sv
verilog/axi_sram.sv
verilog/mem_subsys_top.sv
tb/tb_top.sv

// File: Makefile
# Verilator build and run for the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_top
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary -j 0 --timescale 1ns/1ps

SOURCES := $(wildcard verilog/*.sv) $(wildcard tb/*.sv)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
